/* Makefile */
TOP := csr_unit_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f csr_unit_top.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

/* csr_unit_top.f */
+incdir+sim
logic/csr_pkg.sv
logic/csr_write_decode.sv
logic/csr_machine_regs.sv
logic/csr_trigger_unit.sv
logic/csr_read_mux.sv
logic/csr_unit_top.sv
sim/csr_unit_tb.sv

/* logic/csr_machine_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr machine and debug registers
// holds the machine and debug mode csrs, merges execute
// stage dcsr writes through a field mask and runs the
// 64 bit cycle counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module csr_machine_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_wr_t    wr_i,
    output csr_pkg::csr_state_t state_o
);

    csr_pkg::csr_state_t state_q;
    csr_pkg::csr_data_t  dcsr_next;

    // exu may only touch the writable dcsr fields, exception side writes it whole
    assign dcsr_next = wr_i.from_exu ?
                       ((wr_i.data & csr_pkg::DCSR_EXU_WMASK) |
                        (state_q.dcsr & ~csr_pkg::DCSR_EXU_WMASK)) :
                       wr_i.data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q.mtvec     <= '0;
            state_q.mcause    <= '0;
            state_q.mepc      <= '0;
            state_q.mie       <= '0;
            state_q.mstatus   <= '0;
            state_q.mscratch  <= '0;
            state_q.mhartid   <= '0;
            state_q.dpc       <= '0;
            state_q.dcsr      <= csr_pkg::DCSR_RESET;
            state_q.dscratch0 <= '0;
            state_q.dscratch1 <= '0;
            state_q.cycle     <= '0;
        end else begin
            state_q.cycle <= state_q.cycle + 64'd1;  // free running out of reset

            if (wr_i.mtvec) begin
                state_q.mtvec <= wr_i.data;
            end
            if (wr_i.mcause) begin
                state_q.mcause <= wr_i.data;
            end
            if (wr_i.mepc) begin
                state_q.mepc <= wr_i.data;
            end
            if (wr_i.mie) begin
                state_q.mie <= wr_i.data;
            end
            if (wr_i.mstatus) begin
                state_q.mstatus <= wr_i.data;
            end
            if (wr_i.mscratch) begin
                state_q.mscratch <= wr_i.data;
            end
            if (wr_i.mhartid) begin
                state_q.mhartid <= wr_i.data;
            end

            // debug mode registers
            if (wr_i.dpc) begin
                state_q.dpc <= wr_i.data;
            end
            if (wr_i.dcsr) begin
                state_q.dcsr <= dcsr_next;
            end
            if (wr_i.dscratch0) begin
                state_q.dscratch0 <= wr_i.data;
            end
            if (wr_i.dscratch1) begin
                state_q.dscratch1 <= wr_i.data;
            end
        end
    end

    assign state_o = state_q;

endmodule

/* logic/csr_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr package
// widths, csr addresses, reset and mask constants and the
// struct types shared by the csr block of the rv32 core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;  // the core never decodes more than 12 bits

    typedef logic [XLEN-1:0]       csr_data_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // machine mode
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;
    localparam csr_addr_t CSR_CYCLE     = 12'hC00;
    localparam csr_addr_t CSR_CYCLEH    = 12'hC80;
    // trigger and debug mode
    localparam csr_addr_t CSR_TSELECT   = 12'h7A0;
    localparam csr_addr_t CSR_TDATA1    = 12'h7A1;
    localparam csr_addr_t CSR_TDATA2    = 12'h7A2;
    localparam csr_addr_t CSR_DCSR      = 12'h7B0;
    localparam csr_addr_t CSR_DPC       = 12'h7B1;
    localparam csr_addr_t CSR_DSCRATCH0 = 12'h7B2;
    localparam csr_addr_t CSR_DSCRATCH1 = 12'h7B3;

    localparam csr_data_t MISA_VALUE     = 32'h40001100;  // mxl=1, extensions i and m
    localparam csr_data_t DCSR_RESET     = 32'h40000000;  // xdebugver = 4
    localparam csr_data_t DCSR_EXU_WMASK = 32'h0FFFFE37;  // bits 27:9, 5:4, 2:0

    // hardware breakpoints
    localparam int HW_BP_NUM = 3;
    localparam int TSEL_W    = (HW_BP_NUM > 1) ? $clog2(HW_BP_NUM) : 1;

    // type 2 address match, dmode, action 1 (enter debug), m and u set
    localparam csr_data_t TDATA1_BASE     = 32'h28001048;
    localparam int        TDATA1_EXEC_BIT = 2;

    typedef struct packed {
        logic      we;
        csr_addr_t waddr;
        csr_data_t wdata;
        csr_addr_t raddr;
    } csr_exu_req_t;

    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        csr_data_t data;
    } csr_excep_wr_t;

    // write after arbitration, one select bit per register
    typedef struct packed {
        csr_data_t data;
        logic      from_exu;
        logic      mtvec;
        logic      mcause;
        logic      mepc;
        logic      mie;
        logic      mstatus;
        logic      mscratch;
        logic      mhartid;
        logic      dpc;
        logic      dcsr;
        logic      dscratch0;
        logic      dscratch1;
        logic      tselect;
        logic      tdata1;
        logic      tdata2;
    } csr_wr_t;

    typedef struct packed {
        csr_data_t   mtvec;
        csr_data_t   mcause;
        csr_data_t   mepc;
        csr_data_t   mie;
        csr_data_t   mstatus;
        csr_data_t   mscratch;
        csr_data_t   mhartid;
        csr_data_t   dpc;
        csr_data_t   dcsr;
        csr_data_t   dscratch0;
        csr_data_t   dscratch1;
        logic [63:0] cycle;
    } csr_state_t;

    typedef struct packed {
        csr_data_t tselect;
        csr_data_t tdata1;
        csr_data_t tdata2;
    } csr_trig_rd_t;

endpackage

/* logic/csr_read_mux.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr read path
// combinational read word for the execute stage, picked by
// csr address, unknown addresses read as zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module csr_read_mux (
    input  csr_pkg::csr_addr_t    raddr_i,
    input  csr_pkg::csr_state_t   state_i,
    input  csr_pkg::csr_trig_rd_t trig_rd_i,
    output csr_pkg::csr_data_t    rdata_o
);

    always_comb begin
        case (raddr_i)
            csr_pkg::CSR_CYCLE:     rdata_o = state_i.cycle[31:0];
            csr_pkg::CSR_CYCLEH:    rdata_o = state_i.cycle[63:32];
            csr_pkg::CSR_MISA:      rdata_o = csr_pkg::MISA_VALUE;  // read only constant

            // machine mode
            csr_pkg::CSR_MTVEC:     rdata_o = state_i.mtvec;
            csr_pkg::CSR_MCAUSE:    rdata_o = state_i.mcause;
            csr_pkg::CSR_MEPC:      rdata_o = state_i.mepc;
            csr_pkg::CSR_MIE:       rdata_o = state_i.mie;
            csr_pkg::CSR_MSTATUS:   rdata_o = state_i.mstatus;
            csr_pkg::CSR_MSCRATCH:  rdata_o = state_i.mscratch;
            csr_pkg::CSR_MHARTID:   rdata_o = state_i.mhartid;

            // debug mode
            csr_pkg::CSR_DPC:       rdata_o = state_i.dpc;
            csr_pkg::CSR_DCSR:      rdata_o = state_i.dcsr;
            csr_pkg::CSR_DSCRATCH0: rdata_o = state_i.dscratch0;
            csr_pkg::CSR_DSCRATCH1: rdata_o = state_i.dscratch1;

            // triggers, already resolved for the selected slot
            csr_pkg::CSR_TSELECT:   rdata_o = trig_rd_i.tselect;
            csr_pkg::CSR_TDATA1:    rdata_o = trig_rd_i.tdata1;
            csr_pkg::CSR_TDATA2:    rdata_o = trig_rd_i.tdata2;

            default:                rdata_o = '0;
        endcase
    end

endmodule

/* logic/csr_trigger_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr trigger unit
// hardware breakpoint slots behind tselect, tdata1 and
// tdata2, with an exact match against the fetch address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module csr_trigger_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  csr_pkg::csr_wr_t      wr_i,
    input  csr_pkg::csr_data_t    pc_if_i,
    output csr_pkg::csr_trig_rd_t trig_rd_o,
    output logic                  trigger_match_o
);

    typedef logic [csr_pkg::TSEL_W-1:0] tsel_t;

    tsel_t                         tselect_q;
    tsel_t                         tselect_d;
    logic                          bp_en_q   [csr_pkg::HW_BP_NUM];  // execute bit per slot
    csr_pkg::csr_data_t            bp_addr_q [csr_pkg::HW_BP_NUM];
    logic [csr_pkg::HW_BP_NUM-1:0] slot_match;

    // out of range selects clamp to the last slot
    assign tselect_d = (wr_i.data < csr_pkg::csr_data_t'(csr_pkg::HW_BP_NUM)) ?
                       tsel_t'(wr_i.data) : tsel_t'(csr_pkg::HW_BP_NUM - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tselect_q <= '0;
        end else if (wr_i.tselect) begin
            tselect_q <= tselect_d;
        end
    end

    for (genvar i = 0; i < csr_pkg::HW_BP_NUM; i++) begin : g_slot
        logic slot_sel;

        assign slot_sel = (tselect_q == tsel_t'(i));

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                bp_en_q[i]   <= 1'b0;
                bp_addr_q[i] <= '0;
            end else begin
                if (wr_i.tdata1 && slot_sel) begin
                    bp_en_q[i] <= wr_i.data[csr_pkg::TDATA1_EXEC_BIT];
                end
                if (wr_i.tdata2 && slot_sel) begin
                    bp_addr_q[i] <= wr_i.data;
                end
            end
        end

        // instruction address match, taken before execution
        assign slot_match[i] = bp_en_q[i] && (bp_addr_q[i] == pc_if_i);
    end

    assign trigger_match_o = |slot_match;

    always_comb begin
        trig_rd_o.tselect = csr_pkg::csr_data_t'(tselect_q);
        trig_rd_o.tdata1  = csr_pkg::TDATA1_BASE;
        trig_rd_o.tdata1[csr_pkg::TDATA1_EXEC_BIT] = bp_en_q[tselect_q];
        trig_rd_o.tdata2  = bp_addr_q[tselect_q];
    end

endmodule

/* logic/csr_unit_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr unit top
// control and status registers of the rv32 core: write
// decode, register storage, breakpoint triggers, read path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module csr_unit_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  csr_pkg::csr_exu_req_t  exu_req_i,
    input  csr_pkg::csr_excep_wr_t excep_wr_i,
    input  csr_pkg::csr_data_t     pc_if_i,        // fetch address
    output csr_pkg::csr_data_t     exu_rdata_o,
    output logic                   trigger_match_o,
    output csr_pkg::csr_state_t    csr_state_o
);

    csr_pkg::csr_wr_t      wr;
    csr_pkg::csr_state_t   state;
    csr_pkg::csr_trig_rd_t trig_rd;

    csr_write_decode u_write_decode (
        .exu_req_i  (exu_req_i),
        .excep_wr_i (excep_wr_i),
        .wr_o       (wr)
    );

    csr_machine_regs u_machine_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_i    (wr),
        .state_o (state)
    );

    csr_trigger_unit u_trigger_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_i            (wr),
        .pc_if_i         (pc_if_i),
        .trig_rd_o       (trig_rd),
        .trigger_match_o (trigger_match_o)
    );

    csr_read_mux u_read_mux (
        .raddr_i   (exu_req_i.raddr),
        .state_i   (state),
        .trig_rd_i (trig_rd),
        .rdata_o   (exu_rdata_o)
    );

    assign csr_state_o = state;

endmodule

/* logic/csr_write_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr write decoder
// arbitrates the execute stage and exception writes, then
// turns the winning address into per register selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module csr_write_decode (
    input  csr_pkg::csr_exu_req_t  exu_req_i,
    input  csr_pkg::csr_excep_wr_t excep_wr_i,
    output csr_pkg::csr_wr_t       wr_o
);

    logic               wen;       // any source writing
    logic               from_exu;  // execute stage has priority
    csr_pkg::csr_addr_t waddr;

    always_comb begin
        from_exu = exu_req_i.we;
        wen      = exu_req_i.we | excep_wr_i.valid;
        waddr    = from_exu ? exu_req_i.waddr : excep_wr_i.addr;

        wr_o          = '0;
        wr_o.data     = from_exu ? exu_req_i.wdata : excep_wr_i.data;
        wr_o.from_exu = from_exu;

        if (wen) begin
            case (waddr)
                csr_pkg::CSR_MTVEC: begin
                    wr_o.mtvec = 1'b1;
                end
                csr_pkg::CSR_MCAUSE: begin
                    wr_o.mcause = 1'b1;
                end
                csr_pkg::CSR_MEPC: begin
                    wr_o.mepc = 1'b1;
                end
                csr_pkg::CSR_MIE: begin
                    wr_o.mie = 1'b1;
                end
                csr_pkg::CSR_MSTATUS: begin
                    wr_o.mstatus = 1'b1;
                end
                csr_pkg::CSR_MSCRATCH: begin
                    wr_o.mscratch = 1'b1;
                end
                csr_pkg::CSR_MHARTID: begin
                    wr_o.mhartid = 1'b1;
                end
                csr_pkg::CSR_DPC: begin
                    wr_o.dpc = 1'b1;
                end
                csr_pkg::CSR_DCSR: begin
                    wr_o.dcsr = 1'b1;  // masking happens in the storage
                end
                csr_pkg::CSR_DSCRATCH0: begin
                    wr_o.dscratch0 = 1'b1;
                end
                csr_pkg::CSR_DSCRATCH1: begin
                    wr_o.dscratch1 = 1'b1;
                end
                // trigger registers belong to the execute stage only
                csr_pkg::CSR_TSELECT: begin
                    wr_o.tselect = from_exu;
                end
                csr_pkg::CSR_TDATA1: begin
                    wr_o.tdata1 = from_exu;
                end
                csr_pkg::CSR_TDATA2: begin
                    wr_o.tdata2 = from_exu;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* sim/csr_unit_model.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr unit reference model
// registers, breakpoint slots and cycle count of the csr
// block, advanced by the testbench once per rising edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CSR_UNIT_MODEL_SVH
`define CSR_UNIT_MODEL_SVH

csr_pkg::csr_state_t ref_state;
int                  ref_tsel;                            // selected breakpoint slot
logic                ref_bp_en   [csr_pkg::HW_BP_NUM];
csr_pkg::csr_data_t  ref_bp_addr [csr_pkg::HW_BP_NUM];

task automatic reset_model();
    ref_state      = '0;
    ref_state.dcsr = csr_pkg::DCSR_RESET;
    ref_tsel       = 0;
    for (int i = 0; i < csr_pkg::HW_BP_NUM; i++) begin
        ref_bp_en[i]   = 1'b0;
        ref_bp_addr[i] = '0;
    end
endtask

// one rising edge with rst_n high
task automatic apply_writes(input csr_pkg::csr_exu_req_t exu, input csr_pkg::csr_excep_wr_t exc);
    logic               exu_wins;
    csr_pkg::csr_addr_t a;
    csr_pkg::csr_data_t d;
    csr_pkg::csr_data_t m;
    ref_state.cycle = ref_state.cycle + 64'd1;
    if (exu.we || exc.valid) begin
        exu_wins = exu.we;
        a = exu_wins ? exu.waddr : exc.addr;
        d = exu_wins ? exu.wdata : exc.data;
        m = exu_wins ? csr_pkg::DCSR_EXU_WMASK : '1;  // exception side replaces all of dcsr
        case (a)
            csr_pkg::CSR_MTVEC:     ref_state.mtvec = d;
            csr_pkg::CSR_MCAUSE:    ref_state.mcause = d;
            csr_pkg::CSR_MEPC:      ref_state.mepc = d;
            csr_pkg::CSR_MIE:       ref_state.mie = d;
            csr_pkg::CSR_MSTATUS:   ref_state.mstatus = d;
            csr_pkg::CSR_MSCRATCH:  ref_state.mscratch = d;
            csr_pkg::CSR_MHARTID:   ref_state.mhartid = d;
            csr_pkg::CSR_DPC:       ref_state.dpc = d;
            csr_pkg::CSR_DCSR:      ref_state.dcsr = (d & m) | (ref_state.dcsr & ~m);
            csr_pkg::CSR_DSCRATCH0: ref_state.dscratch0 = d;
            csr_pkg::CSR_DSCRATCH1: ref_state.dscratch1 = d;
            csr_pkg::CSR_TSELECT: begin
                if (exu_wins) begin
                    ref_tsel = (d >= csr_pkg::csr_data_t'(csr_pkg::HW_BP_NUM)) ?
                               csr_pkg::HW_BP_NUM - 1 : int'(d);
                end
            end
            csr_pkg::CSR_TDATA1: begin
                if (exu_wins) ref_bp_en[ref_tsel] = d[csr_pkg::TDATA1_EXEC_BIT];
            end
            csr_pkg::CSR_TDATA2: begin
                if (exu_wins) ref_bp_addr[ref_tsel] = d;
            end
            default: ;
        endcase
    end
endtask

function automatic csr_pkg::csr_data_t expected_read(input csr_pkg::csr_addr_t addr);
    csr_pkg::csr_data_t tdata1;
    tdata1 = csr_pkg::TDATA1_BASE;
    tdata1[csr_pkg::TDATA1_EXEC_BIT] = ref_bp_en[ref_tsel];
    case (addr)
        csr_pkg::CSR_MTVEC:     return ref_state.mtvec;
        csr_pkg::CSR_MCAUSE:    return ref_state.mcause;
        csr_pkg::CSR_MEPC:      return ref_state.mepc;
        csr_pkg::CSR_MIE:       return ref_state.mie;
        csr_pkg::CSR_MSTATUS:   return ref_state.mstatus;
        csr_pkg::CSR_MSCRATCH:  return ref_state.mscratch;
        csr_pkg::CSR_MHARTID:   return ref_state.mhartid;
        csr_pkg::CSR_DPC:       return ref_state.dpc;
        csr_pkg::CSR_DCSR:      return ref_state.dcsr;
        csr_pkg::CSR_DSCRATCH0: return ref_state.dscratch0;
        csr_pkg::CSR_DSCRATCH1: return ref_state.dscratch1;
        csr_pkg::CSR_CYCLE:     return ref_state.cycle[31:0];
        csr_pkg::CSR_CYCLEH:    return ref_state.cycle[63:32];
        csr_pkg::CSR_MISA:      return csr_pkg::MISA_VALUE;
        csr_pkg::CSR_TSELECT:   return csr_pkg::csr_data_t'(ref_tsel);
        csr_pkg::CSR_TDATA1:    return tdata1;
        csr_pkg::CSR_TDATA2:    return ref_bp_addr[ref_tsel];
        default:                return '0;  // unknown csr
    endcase
endfunction

function automatic logic expected_match(input csr_pkg::csr_data_t pc);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < csr_pkg::HW_BP_NUM; i++) begin
        if (ref_bp_en[i] && (ref_bp_addr[i] == pc)) hit = 1'b1;
    end
    return hit;
endfunction

`endif

/* sim/csr_unit_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr unit testbench
// random execute stage and exception traffic checked against
// a reference model for reads, register state and breakpoint match
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module csr_unit_tb;

    localparam int RST_CYCLES = 8;
    localparam int N_ADDR     = 17;
    localparam int N_RAND     = 2000;
    localparam int MAX_CYCLES = RST_CYCLES + N_ADDR + N_RAND + 200;

    logic                   clk;
    logic                   rst_n;
    csr_pkg::csr_exu_req_t  exu_req;
    csr_pkg::csr_excep_wr_t excep_wr;
    csr_pkg::csr_data_t     pc_if;
    csr_pkg::csr_data_t     exu_rdata;
    logic                   trigger_match;
    csr_pkg::csr_state_t    csr_state;
    logic [31:0]            lcg_state;
    int                     cycle_cnt = 0;
    csr_pkg::csr_addr_t     addr_tab [N_ADDR];

    `include "csr_unit_model.svh"

    csr_unit_top dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .exu_req_i       (exu_req),
        .excep_wr_i      (excep_wr),
        .pc_if_i         (pc_if),
        .exu_rdata_o     (exu_rdata),
        .trigger_match_o (trigger_match),
        .csr_state_o     (csr_state)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            stop_on_error($sformatf("ERROR: run did not end within %0d cycles", MAX_CYCLES));
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_word(input string name, input csr_pkg::csr_data_t exp,
                              input csr_pkg::csr_data_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_match(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_state(input csr_pkg::csr_state_t exp, input csr_pkg::csr_state_t act);
        check_word("csr_state_o.mtvec", exp.mtvec, act.mtvec);
        check_word("csr_state_o.mcause", exp.mcause, act.mcause);
        check_word("csr_state_o.mepc", exp.mepc, act.mepc);
        check_word("csr_state_o.mie", exp.mie, act.mie);
        check_word("csr_state_o.mstatus", exp.mstatus, act.mstatus);
        check_word("csr_state_o.mscratch", exp.mscratch, act.mscratch);
        check_word("csr_state_o.mhartid", exp.mhartid, act.mhartid);
        check_word("csr_state_o.dpc", exp.dpc, act.dpc);
        check_word("csr_state_o.dcsr", exp.dcsr, act.dcsr);
        check_word("csr_state_o.dscratch0", exp.dscratch0, act.dscratch0);
        check_word("csr_state_o.dscratch1", exp.dscratch1, act.dscratch1);
        check_word("csr_state_o.cycle[31:0]", exp.cycle[31:0], act.cycle[31:0]);
        check_word("csr_state_o.cycle[63:32]", exp.cycle[63:32], act.cycle[63:32]);
    endtask

    // entered 1 ns after a rising edge, leaves 1 ns after the next one
    task automatic step(input csr_pkg::csr_exu_req_t exu, input csr_pkg::csr_excep_wr_t exc,
                        input csr_pkg::csr_data_t pc);
        exu_req  = exu;
        excep_wr = exc;
        pc_if    = pc;
        #1;
        check_word("exu_rdata_o", expected_read(exu.raddr), exu_rdata);
        check_match("trigger_match_o", expected_match(pc), trigger_match);
        check_state(ref_state, csr_state);
        @(posedge clk);
        apply_writes(exu, exc);
        #1;
    endtask

    function automatic csr_pkg::csr_addr_t pick_addr();
        logic [31:0] r;
        r = next_rand();
        if (r[31:29] == 3'd0) return r[11:0];  // now and then an unlisted one
        return addr_tab[int'(r[15:8]) % N_ADDR];
    endfunction

    task automatic random_cycle();
        logic [31:0]            r;
        csr_pkg::csr_exu_req_t  exu;
        csr_pkg::csr_excep_wr_t exc;
        csr_pkg::csr_data_t     pc;
        r         = next_rand();
        exu.we    = r[0];
        exu.waddr = pick_addr();
        exu.wdata = next_rand();
        exu.raddr = pick_addr();
        exc.valid = (r[2:1] == 2'b00);
        exc.addr  = pick_addr();
        exc.data  = next_rand();
        if (exu.waddr == csr_pkg::CSR_TSELECT) exu.wdata = {29'd0, r[5:3]};  // some saturate
        pc = next_rand();
        if (r[6]) pc = ref_bp_addr[int'(r[9:8]) % csr_pkg::HW_BP_NUM];  // aim at a slot
        step(exu, exc, pc);
    endtask

    initial begin
        csr_pkg::csr_exu_req_t idle;
        lcg_state = 32'h18ea19e1;
        addr_tab  = '{csr_pkg::CSR_MTVEC, csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MEPC,
                      csr_pkg::CSR_MIE, csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MSCRATCH,
                      csr_pkg::CSR_MHARTID, csr_pkg::CSR_MISA, csr_pkg::CSR_DPC,
                      csr_pkg::CSR_DCSR, csr_pkg::CSR_DSCRATCH0, csr_pkg::CSR_DSCRATCH1,
                      csr_pkg::CSR_CYCLE, csr_pkg::CSR_CYCLEH, csr_pkg::CSR_TSELECT,
                      csr_pkg::CSR_TDATA1, csr_pkg::CSR_TDATA2};
        rst_n    = 1'b0;
        exu_req  = '0;
        excep_wr = '0;
        pc_if    = '0;
        reset_model();
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset values read back at one listed address per cycle
        for (int i = 0; i < N_ADDR; i++) begin
            idle       = '0;
            idle.raddr = addr_tab[i];
            step(idle, '0, '0);
        end

        repeat (N_RAND) random_cycle();
        $display("** PASS **");
        $finish;
    end

endmodule
